/* flist.f */
hdl/ex_op_pkg.sv
hdl/ex_data_pkg.sv
hdl/alu_arith.sv
hdl/alu_logic_shift.sv
hdl/mult_unit.sv
hdl/div_unit.sv
hdl/ex_control.sv
hdl/ex_unit.sv
tests/tb_ex_unit.sv

/* Makefile */
TOP := tb_ex_unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_ex_unit.sv */
`timescale 1ns/1ps

module tb_ex_unit;
    localparam int MULT_STAGES = 4;
    localparam int MUL_TIMEOUT = 20;
    localparam int DIV_TIMEOUT = 60;

    logic                      clk;
    logic                      rst_n;
    ex_data_pkg::ex_operands_t operands;
    ex_op_pkg::alu_op_e        alu_op;
    ex_data_pkg::wide_result_t hilo;
    logic                      start_mul_div;
    logic                      flush_e;
    logic                      flush_exc_m;
    logic                      stall_m;
    ex_data_pkg::wide_result_t alu_out;
    logic                      overflow;
    logic                      mul_stall;
    logic                      div_stall;

    ex_data_pkg::wide_result_t exp_out;
    logic                      exp_ovf;
    logic                      chk_comb;      // same-cycle result
    logic                      chk_res;       // result once both stalls are low
    logic                      chk_mul;       // stall length at the fall
    logic                      chk_nostall;
    logic [31:0]               lcg_state;
    int                        assert_errs = 0;
    int                        timeout_errs;
    int                        test_cnt;
    int                        mul_run;
    logic                      mul_prev;

    ex_op_pkg::alu_op_e ls_ops [12] = '{ex_op_pkg::ALU_AND, ex_op_pkg::ALU_OR,
        ex_op_pkg::ALU_NOR, ex_op_pkg::ALU_XOR, ex_op_pkg::ALU_SLL, ex_op_pkg::ALU_SLL_SA,
        ex_op_pkg::ALU_SRL, ex_op_pkg::ALU_SRA, ex_op_pkg::ALU_SRL_SA, ex_op_pkg::ALU_SRA_SA,
        ex_op_pkg::ALU_LUI, ex_op_pkg::ALU_PASS};
    ex_op_pkg::alu_op_e arith_ops [6] = '{ex_op_pkg::ALU_ADD, ex_op_pkg::ALU_ADDU,
        ex_op_pkg::ALU_SUB, ex_op_pkg::ALU_SUBU, ex_op_pkg::ALU_SLT, ex_op_pkg::ALU_SLTU};

    ex_unit #(
        .MULT_STAGES(MULT_STAGES)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .operands     (operands),
        .alu_op       (alu_op),
        .hilo         (hilo),
        .start_mul_div(start_mul_div),
        .flush_e      (flush_e),
        .flush_exc_m  (flush_exc_m),
        .stall_m      (stall_m),
        .alu_out      (alu_out),
        .overflow     (overflow),
        .mul_stall    (mul_stall),
        .div_stall    (div_stall)
    );

    always #5 clk = ~clk;

    // length of the current mul_stall run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_run  <= 0;
            mul_prev <= 1'b0;
        end else begin
            mul_prev <= mul_stall;
            mul_run  <= mul_stall ? mul_run + 1 : 0;
        end
    end

    comb_check: assert property (@(posedge clk) disable iff (!rst_n)
        chk_comb |-> (alu_out == exp_out && overflow == exp_ovf))
    else begin
        assert_errs++;
        $display("[FAIL] %0t: %s gave %h ovf %b, expected %h ovf %b", $time,
                 alu_op.name(), alu_out, overflow, exp_out, exp_ovf);
    end

    result_check: assert property (@(posedge clk) disable iff (!rst_n)
        (chk_res && !mul_stall && !div_stall) |-> (alu_out == exp_out))
    else begin
        assert_errs++;
        $display("[FAIL] %0t: %s result %h, expected %h", $time, alu_op.name(),
                 alu_out, exp_out);
    end

    mul_len_check: assert property (@(posedge clk) disable iff (!rst_n)
        (chk_mul && mul_prev && !mul_stall) |-> (mul_run == MULT_STAGES))
    else begin
        assert_errs++;
        $display("[FAIL] %0t: mul_stall high for %0d cycles, expected %0d", $time,
                 mul_run, MULT_STAGES);
    end

    nostall_check: assert property (@(posedge clk) disable iff (!rst_n)
        chk_nostall |-> (!mul_stall && !div_stall))
    else begin
        assert_errs++;
        $display("[FAIL] %0t: stall high, mul_stall %b div_stall %b", $time,
                 mul_stall, div_stall);
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic ex_data_pkg::wide_result_t alu_result(input ex_op_pkg::alu_op_e op,
        input logic [31:0] a, input logic [31:0] b, input logic [4:0] sa,
        input ex_data_pkg::wide_result_t hl);
        ex_data_pkg::wide_result_t r;
        r.hi = '0;
        case (op)
            ex_op_pkg::ALU_AND:    r.lo = a & b;
            ex_op_pkg::ALU_OR:     r.lo = a | b;
            ex_op_pkg::ALU_NOR:    r.lo = ~(a | b);
            ex_op_pkg::ALU_XOR:    r.lo = a ^ b;
            ex_op_pkg::ALU_ADD, ex_op_pkg::ALU_ADDU: r.lo = a + b;
            ex_op_pkg::ALU_SUB, ex_op_pkg::ALU_SUBU: r.lo = a - b;
            ex_op_pkg::ALU_SLT:    r.lo = {31'd0, $signed(a) < $signed(b)};
            ex_op_pkg::ALU_SLTU:   r.lo = {31'd0, a < b};
            ex_op_pkg::ALU_SLL:    r.lo = b << a[4:0];
            ex_op_pkg::ALU_SLL_SA: r.lo = b << sa;
            ex_op_pkg::ALU_SRL:    r.lo = b >> a[4:0];
            ex_op_pkg::ALU_SRA:    r.lo = $signed(b) >>> a[4:0];
            ex_op_pkg::ALU_SRL_SA: r.lo = b >> sa;
            ex_op_pkg::ALU_SRA_SA: r.lo = $signed(b) >>> sa;
            ex_op_pkg::ALU_LUI:    r.lo = {b[15:0], 16'h0000};
            ex_op_pkg::ALU_MTHI: begin
                r.hi = a;
                r.lo = hl.lo;
            end
            ex_op_pkg::ALU_MTLO: begin
                r.hi = hl.hi;
                r.lo = a;
            end
            default:               r.lo = a;
        endcase
        return r;
    endfunction

    function automatic logic signed_overflow(input ex_op_pkg::alu_op_e op,
        input logic [31:0] a, input logic [31:0] b);
        logic [32:0] wide;
        if (op == ex_op_pkg::ALU_ADD) begin
            wide = {a[31], a} + {b[31], b};
        end else if (op == ex_op_pkg::ALU_SUB) begin
            wide = {a[31], a} - {b[31], b};
        end else begin
            wide = '0;
        end
        return wide[32] ^ wide[31];   // 33-bit sum disagrees with 32-bit sign
    endfunction

    function automatic logic [63:0] mult_product(input logic signed_mode,
        input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] a64;
        logic signed [63:0] b64;
        if (signed_mode) begin
            a64 = $signed({{32{a[31]}}, a});
            b64 = $signed({{32{b[31]}}, b});
            return a64 * b64;
        end
        return {32'd0, a} * {32'd0, b};
    endfunction

    function automatic ex_data_pkg::wide_result_t div_result(input logic signed_mode,
        input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] a64;
        logic signed [63:0] b64;
        logic signed [63:0] q64;
        logic signed [63:0] m64;
        ex_data_pkg::wide_result_t r;
        if (b == 32'd0) begin
            r.hi = a;
            r.lo = '1;
        end else if (signed_mode) begin
            a64 = $signed({{32{a[31]}}, a});
            b64 = $signed({{32{b[31]}}, b});
            q64 = a64 / b64;   // truncates toward zero
            m64 = a64 % b64;
            r.hi = m64[31:0];
            r.lo = q64[31:0];
        end else begin
            r.hi = a % b;
            r.lo = a / b;
        end
        return r;
    endfunction

    task automatic drive_comb(input ex_op_pkg::alu_op_e op, input logic [31:0] a,
        input logic [31:0] b, input logic [4:0] sa, input ex_data_pkg::wide_result_t hl);
        @(negedge clk);
        alu_op         = op;
        operands.src_a = a;
        operands.src_b = b;
        operands.sa    = sa;
        hilo           = hl;
        exp_out        = alu_result(op, a, b, sa, hl);
        exp_ovf        = signed_overflow(op, a, b);
        chk_comb       = 1'b1;
    endtask

    task automatic arith_sweep(input logic [31:0] a, input logic [31:0] b);
        for (int k = 0; k < 6; k++) begin
            drive_comb(arith_ops[k], a, b, 5'd0, '0);
        end
    endtask

    task automatic end_checks();
        @(negedge clk);
        chk_comb = 1'b0;
    endtask

    task automatic wait_stall_fall(input logic is_div, input int limit);
        int n;
        n = 0;
        while ((is_div ? div_stall : mul_stall) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (is_div ? div_stall : mul_stall) begin
            timeout_errs++;
            $display("timeout at %0t: %s stall still high after %0d cycles", $time,
                     is_div ? "div" : "mul", limit);
        end
    endtask

    task automatic run_mult(input ex_op_pkg::alu_op_e op, input logic [31:0] a,
        input logic [31:0] b, input logic exc);
        @(negedge clk);
        alu_op         = op;
        operands.src_a = a;
        operands.src_b = b;
        exp_out        = mult_product(op == ex_op_pkg::ALU_MULT, a, b);
        start_mul_div  = 1'b1;
        flush_exc_m    = exc;
        chk_nostall    = exc;
        chk_mul        = ~exc;
        @(negedge clk);
        start_mul_div = 1'b0;
        if (exc) begin
            repeat (MULT_STAGES) @(negedge clk);
            flush_exc_m = 1'b0;
            chk_nostall = 1'b0;
        end else begin
            wait_stall_fall(1'b0, MUL_TIMEOUT);
        end
        chk_res = 1'b1;
        @(negedge clk);
        chk_res = 1'b0;
        chk_mul = 1'b0;
    endtask

    task automatic run_div(input ex_op_pkg::alu_op_e op, input logic [31:0] a,
        input logic [31:0] b, input int hold);
        @(negedge clk);
        alu_op         = op;
        operands.src_a = a;
        operands.src_b = b;
        exp_out        = div_result(op == ex_op_pkg::ALU_DIV, a, b);
        start_mul_div  = 1'b1;
        stall_m        = (hold > 0);
        @(negedge clk);
        start_mul_div = 1'b0;
        wait_stall_fall(1'b1, DIV_TIMEOUT);
        chk_res = 1'b1;
        repeat (hold) @(negedge clk);   // memory still stalled, result must hold
        stall_m = 1'b0;
        @(negedge clk);
        chk_res = 1'b0;
    endtask

    task automatic abort_div(input logic [31:0] a, input logic [31:0] b);
        @(negedge clk);
        alu_op         = ex_op_pkg::ALU_DIV;
        operands.src_a = a;
        operands.src_b = b;
        start_mul_div  = 1'b1;
        @(negedge clk);
        start_mul_div = 1'b0;
        repeat (5) @(negedge clk);
        flush_e = 1'b1;
        @(negedge clk);
        flush_e = 1'b0;
        @(negedge clk);
        chk_nostall = 1'b1;   // second cycle after the flush
        @(negedge clk);
        chk_nostall = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        int errs;
        errs = assert_errs + timeout_errs - errs_at_start;
        test_cnt++;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, name, errs);
        end
    endtask

    initial begin
        int                        errs;
        int                        idx;
        logic [31:0]               ra;
        logic [31:0]               rb;
        logic [31:0]               rs;
        ex_data_pkg::wide_result_t hl;
        clk           = 1'b0;
        rst_n         = 1'b0;
        operands      = '0;
        alu_op        = ex_op_pkg::ALU_PASS;
        hilo          = '0;
        start_mul_div = 1'b0;
        flush_e       = 1'b0;
        flush_exc_m   = 1'b0;
        stall_m       = 1'b0;
        exp_out       = '0;
        exp_ovf       = 1'b0;
        chk_comb      = 1'b0;
        chk_res       = 1'b0;
        chk_mul       = 1'b0;
        chk_nostall   = 1'b0;
        lcg_state     = 32'hc81a_e8df;
        timeout_errs  = 0;
        test_cnt      = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        errs = assert_errs + timeout_errs;
        for (int i = 0; i < 48; i++) begin
            ra  = lcg_next();
            rb  = lcg_next();
            rs  = lcg_next();
            idx = int'(rs[7:0]) % 12;
            drive_comb(ls_ops[idx], ra, rb, rs[12:8], '0);
        end
        end_checks();
        report_test("logic_shift", errs);

        errs = assert_errs + timeout_errs;
        arith_sweep(32'h7fff_ffff, 32'h0000_0001);
        arith_sweep(32'h8000_0000, 32'h0000_0001);
        arith_sweep(32'h8000_0000, 32'h8000_0000);
        arith_sweep(32'h0000_0000, 32'h8000_0000);
        arith_sweep(32'hffff_ffff, 32'h0000_0001);
        arith_sweep(32'h1234_5678, 32'h1234_5678);
        arith_sweep(32'h8000_0000, 32'h7fff_ffff);
        for (int i = 0; i < 32; i++) begin
            ra = lcg_next();
            rb = lcg_next();
            arith_sweep(ra, rb);
        end
        end_checks();
        report_test("arith_slt", errs);

        errs = assert_errs + timeout_errs;
        for (int i = 0; i < 16; i++) begin
            ra    = lcg_next();
            hl.hi = lcg_next();
            hl.lo = lcg_next();
            drive_comb(ex_op_pkg::ALU_MTHI, ra, 32'd0, 5'd0, hl);
            drive_comb(ex_op_pkg::ALU_MTLO, ra, 32'd0, 5'd0, hl);
        end
        end_checks();
        report_test("mthi_mtlo", errs);

        errs = assert_errs + timeout_errs;
        run_mult(ex_op_pkg::ALU_MULT, 32'h8000_0000, 32'h8000_0000, 1'b0);
        run_mult(ex_op_pkg::ALU_MULT, 32'hffff_ffff, 32'h0000_0003, 1'b0);
        run_mult(ex_op_pkg::ALU_MULTU, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
        run_mult(ex_op_pkg::ALU_MULT, 32'h7fff_ffff, 32'h8000_0000, 1'b0);
        for (int i = 0; i < 12; i++) begin
            ra = lcg_next();
            rb = lcg_next();
            rs = lcg_next();
            run_mult(rs[0] ? ex_op_pkg::ALU_MULT : ex_op_pkg::ALU_MULTU, ra, rb, 1'b0);
        end
        run_mult(ex_op_pkg::ALU_MULT, lcg_next(), 32'hfedc_ba98, 1'b1);
        report_test("mult", errs);

        errs = assert_errs + timeout_errs;
        run_div(ex_op_pkg::ALU_DIVU, 32'd100, 32'd7, 0);
        run_div(ex_op_pkg::ALU_DIV, 32'hffff_ff9c, 32'd7, 0);
        run_div(ex_op_pkg::ALU_DIV, 32'd100, 32'hffff_fff9, 0);
        run_div(ex_op_pkg::ALU_DIV, 32'hffff_ff9c, 32'hffff_fff9, 3);
        run_div(ex_op_pkg::ALU_DIV, 32'h8000_0000, 32'hffff_ffff, 0);
        run_div(ex_op_pkg::ALU_DIV, 32'hffff_ff9c, 32'd0, 2);
        run_div(ex_op_pkg::ALU_DIVU, 32'h1234_5678, 32'd0, 0);
        for (int i = 0; i < 8; i++) begin
            ra = lcg_next();
            rb = lcg_next();
            rs = lcg_next();
            run_div(rs[2] ? ex_op_pkg::ALU_DIV : ex_op_pkg::ALU_DIVU, ra, rb >> rs[7:3],
                    int'(rs[1:0]));
        end
        report_test("div", errs);

        errs = assert_errs + timeout_errs;
        abort_div(lcg_next(), 32'd9);
        run_div(ex_op_pkg::ALU_DIV, lcg_next(), 32'hffff_fff3, 0);
        abort_div(32'h8000_0000, lcg_next());
        run_div(ex_op_pkg::ALU_DIVU, lcg_next(), 32'd1234, 1);
        report_test("div_flush", errs);

        $display("summary: %0d tests, %0d assertion errors, %0d timeouts", test_cnt,
                 assert_errs, timeout_errs);
        if (assert_errs + timeout_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* hdl/ex_unit.sv */
`timescale 1ns/1ps

module ex_unit #(
    parameter int MULT_STAGES = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ex_data_pkg::ex_operands_t operands,
    input  ex_op_pkg::alu_op_e        alu_op,
    input  ex_data_pkg::wide_result_t hilo,
    input  logic                      start_mul_div,
    input  logic                      flush_e,
    input  logic                      flush_exc_m,
    input  logic                      stall_m,
    output ex_data_pkg::wide_result_t alu_out,
    output logic                      overflow,
    output logic                      mul_stall,
    output logic                      div_stall
);
    ex_op_pkg::ex_ctrl_t       ctrl;
    logic [31:0]               arith_res;
    logic [31:0]               logic_res;
    ex_data_pkg::wide_result_t mult_res;
    ex_data_pkg::wide_result_t div_res;
    logic                      mult_start;
    logic                      mult_signed;
    logic                      div_start;
    logic                      div_signed;
    logic                      div_ack;
    logic                      div_done;

    ex_control #(
        .MULT_STAGES(MULT_STAGES)
    ) u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .alu_op       (alu_op),
        .start_mul_div(start_mul_div),
        .flush_e      (flush_e),
        .flush_exc_m  (flush_exc_m),
        .stall_m      (stall_m),
        .hilo         (hilo),
        .src_a        (operands.src_a),
        .arith_res    (arith_res),
        .logic_res    (logic_res),
        .mult_res     (mult_res),
        .div_res      (div_res),
        .div_done     (div_done),
        .ctrl         (ctrl),
        .mult_start   (mult_start),
        .mult_signed  (mult_signed),
        .div_start    (div_start),
        .div_signed   (div_signed),
        .div_ack      (div_ack),
        .alu_out      (alu_out),
        .mul_stall    (mul_stall),
        .div_stall    (div_stall)
    );

    alu_arith u_arith (
        .src_a   (operands.src_a),
        .src_b   (operands.src_b),
        .ctrl    (ctrl),
        .sum     (),
        .slt_bit (),
        .sltu_bit(),
        .overflow(overflow),
        .result  (arith_res)
    );

    alu_logic_shift u_logic_shift (
        .src_a (operands.src_a),
        .src_b (operands.src_b),
        .sa    (operands.sa),
        .ctrl  (ctrl),
        .result(logic_res)
    );

    mult_unit #(
        .MULT_STAGES(MULT_STAGES)
    ) u_mult (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush_e  (flush_e),
        .start    (mult_start),
        .is_signed(mult_signed),
        .a        (operands.src_a),
        .b        (operands.src_b),
        .product  (mult_res)
    );

    div_unit u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush_e  (flush_e),
        .start    (div_start),
        .is_signed(div_signed),
        .dividend (operands.src_a),
        .divisor  (operands.src_b),
        .ack      (div_ack),
        .done     (div_done),
        .result   (div_res)
    );

endmodule

/* hdl/ex_control.sv */
`timescale 1ns/1ps

module ex_control #(
    parameter int MULT_STAGES = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ex_op_pkg::alu_op_e        alu_op,
    input  logic                      start_mul_div,
    input  logic                      flush_e,
    input  logic                      flush_exc_m,
    input  logic                      stall_m,
    input  ex_data_pkg::wide_result_t hilo,
    input  logic [31:0]               src_a,
    input  logic [31:0]               arith_res,
    input  logic [31:0]               logic_res,
    input  ex_data_pkg::wide_result_t mult_res,
    input  ex_data_pkg::wide_result_t div_res,
    input  logic                      div_done,
    output ex_op_pkg::ex_ctrl_t       ctrl,
    output logic                      mult_start,
    output logic                      mult_signed,
    output logic                      div_start,
    output logic                      div_signed,
    output logic                      div_ack,
    output ex_data_pkg::wide_result_t alu_out,
    output logic                      mul_stall,
    output logic                      div_stall
);
    localparam int CNT_W = $clog2(MULT_STAGES + 1);

    ex_op_pkg::res_sel_e res_sel;
    logic [CNT_W-1:0]    mul_cnt;
    logic                div_busy;

    always_comb begin
        ctrl = '0;
        res_sel = ex_op_pkg::RES_LS;
        case (alu_op)
            ex_op_pkg::ALU_AND: ctrl.logic_sel = ex_op_pkg::LOGIC_AND;
            ex_op_pkg::ALU_OR:  ctrl.logic_sel = ex_op_pkg::LOGIC_OR;
            ex_op_pkg::ALU_NOR: ctrl.logic_sel = ex_op_pkg::LOGIC_NOR;
            ex_op_pkg::ALU_XOR: ctrl.logic_sel = ex_op_pkg::LOGIC_XOR;
            ex_op_pkg::ALU_ADD: begin
                res_sel = ex_op_pkg::RES_ARITH;
                ctrl.trap_en = 1'b1;
            end
            ex_op_pkg::ALU_ADDU: res_sel = ex_op_pkg::RES_ARITH;
            ex_op_pkg::ALU_SUB: begin
                res_sel = ex_op_pkg::RES_ARITH;
                ctrl.sub_en = 1'b1;
                ctrl.trap_en = 1'b1;
            end
            ex_op_pkg::ALU_SUBU, ex_op_pkg::ALU_SLT, ex_op_pkg::ALU_SLTU: begin
                res_sel = ex_op_pkg::RES_ARITH;
                ctrl.sub_en = 1'b1;
                ctrl.slt_en = (alu_op != ex_op_pkg::ALU_SUBU);
                ctrl.signed_op = (alu_op == ex_op_pkg::ALU_SLT);
            end
            ex_op_pkg::ALU_SLL, ex_op_pkg::ALU_SLL_SA, ex_op_pkg::ALU_SRL,
            ex_op_pkg::ALU_SRA, ex_op_pkg::ALU_SRL_SA, ex_op_pkg::ALU_SRA_SA: begin
                ctrl.ls_sel = ex_op_pkg::LS_SHIFT;
                ctrl.shift_by_sa = alu_op inside {ex_op_pkg::ALU_SLL_SA,
                                                  ex_op_pkg::ALU_SRL_SA,
                                                  ex_op_pkg::ALU_SRA_SA};
                ctrl.shift_right = !(alu_op inside {ex_op_pkg::ALU_SLL,
                                                    ex_op_pkg::ALU_SLL_SA});
                ctrl.shift_arith = alu_op inside {ex_op_pkg::ALU_SRA,
                                                  ex_op_pkg::ALU_SRA_SA};
            end
            ex_op_pkg::ALU_LUI:  ctrl.ls_sel = ex_op_pkg::LS_LUI;
            ex_op_pkg::ALU_MTHI: res_sel = ex_op_pkg::RES_MTHI;
            ex_op_pkg::ALU_MTLO: res_sel = ex_op_pkg::RES_MTLO;
            ex_op_pkg::ALU_MULT, ex_op_pkg::ALU_MULTU: begin
                res_sel = ex_op_pkg::RES_MULT;
                ctrl.signed_op = (alu_op == ex_op_pkg::ALU_MULT);
            end
            ex_op_pkg::ALU_DIV, ex_op_pkg::ALU_DIVU: begin
                res_sel = ex_op_pkg::RES_DIV;
                ctrl.signed_op = (alu_op == ex_op_pkg::ALU_DIV);
            end
            default: ctrl.ls_sel = ex_op_pkg::LS_PASS;
        endcase
    end

    assign mult_start  = start_mul_div & ~flush_e & (res_sel == ex_op_pkg::RES_MULT);
    assign div_start   = start_mul_div & ~flush_e & (res_sel == ex_op_pkg::RES_DIV);
    assign mult_signed = ctrl.signed_op;
    assign div_signed  = ctrl.signed_op;
    assign div_ack     = div_done & ~stall_m;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_cnt <= '0;
        end else if (flush_e) begin
            mul_cnt <= '0;
        end else if (mult_start) begin
            mul_cnt <= CNT_W'(1);
        end else if (mul_cnt == CNT_W'(MULT_STAGES - 1)) begin
            mul_cnt <= '0;               // product lands next cycle
        end else if (mul_cnt != '0) begin
            mul_cnt <= mul_cnt + CNT_W'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_busy <= 1'b0;
        end else if (flush_e || div_ack) begin
            div_busy <= 1'b0;
        end else if (div_start) begin
            div_busy <= 1'b1;
        end
    end

    assign mul_stall = (mult_start | (mul_cnt != '0)) & ~flush_exc_m;
    assign div_stall = (div_start | div_busy) & ~div_done & ~flush_exc_m;

    always_comb begin
        case (res_sel)
            ex_op_pkg::RES_ARITH: begin
                alu_out.hi = '0;
                alu_out.lo = arith_res;
            end
            ex_op_pkg::RES_MULT: alu_out = mult_res;
            ex_op_pkg::RES_DIV:  alu_out = div_res;
            ex_op_pkg::RES_MTHI: begin
                alu_out.hi = src_a;
                alu_out.lo = hilo.lo;
            end
            ex_op_pkg::RES_MTLO: begin
                alu_out.hi = hilo.hi;
                alu_out.lo = src_a;
            end
            default: begin
                alu_out.hi = '0;
                alu_out.lo = logic_res;
            end
        endcase
    end

endmodule

/* hdl/div_unit.sv */
`timescale 1ns/1ps

module div_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_e,
    input  logic                      start,
    input  logic                      is_signed,
    input  logic [31:0]               dividend,
    input  logic [31:0]               divisor,
    input  logic                      ack,
    output logic                      done,
    output ex_data_pkg::wide_result_t result
);
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e  state;
    logic [4:0]  cnt;
    logic [31:0] rem_q;
    logic [31:0] quo_q;
    logic [31:0] dvs_q;
    logic        neg_quo;
    logic        neg_rem;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic [32:0] rem_sh;
    logic [32:0] diff;
    logic [31:0] rem_nx;
    logic [31:0] quo_nx;

    assign a_mag = (is_signed & dividend[31]) ? -dividend : dividend;
    assign b_mag = (is_signed & divisor[31]) ? -divisor : divisor;

    // one restoring step, quotient bits shift in from the right
    assign rem_sh = {rem_q, quo_q[31]};
    assign diff   = rem_sh - {1'b0, dvs_q};
    assign rem_nx = diff[32] ? rem_sh[31:0] : diff[31:0];
    assign quo_nx = {quo_q[30:0], ~diff[32]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else if (flush_e) begin
            state <= DIV_IDLE;
        end else if (start) begin
            state <= (divisor == '0) ? DIV_DONE : DIV_RUN;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_RUN: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'd31) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    if (ack) begin
                        state <= DIV_IDLE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q   <= '0;
            quo_q   <= a_mag;
            dvs_q   <= b_mag;
            neg_quo <= is_signed & (dividend[31] ^ divisor[31]);
            neg_rem <= is_signed & dividend[31];   // remainder follows dividend
            if (divisor == '0) begin
                result.hi <= dividend;
                result.lo <= '1;
            end
        end else if (state == DIV_RUN) begin
            rem_q <= rem_nx;
            quo_q <= quo_nx;
            if (cnt == 5'd31) begin
                result.hi <= neg_rem ? -rem_nx : rem_nx;
                result.lo <= neg_quo ? -quo_nx : quo_nx;
            end
        end
    end

    assign done = (state == DIV_DONE);

endmodule

/* hdl/mult_unit.sv */
`timescale 1ns/1ps

module mult_unit #(
    parameter int MULT_STAGES = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_e,
    input  logic                      start,
    input  logic                      is_signed,
    input  logic [31:0]               a,
    input  logic [31:0]               b,
    output ex_data_pkg::wide_result_t product
);
    // stage 0 holds operands and each later stage adds one chunk of b
    localparam int NSUM  = MULT_STAGES - 1;
    localparam int CHUNK = (32 + NSUM - 1) / NSUM;

    logic [63:0]     a_q   [NSUM];
    logic [63:0]     b_q   [NSUM];
    logic [63:0]     acc_q [MULT_STAGES];
    logic [63:0]     pp    [NSUM];
    logic [NSUM-1:0] vld;

    always_comb begin
        for (int s = 0; s < NSUM; s++) begin
            pp[s] = '0;
            for (int i = 0; i < CHUNK; i++) begin
                if (b_q[s][s * CHUNK + i]) begin
                    pp[s] = pp[s] + (a_q[s] << (s * CHUNK + i));
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
        end else if (flush_e) begin
            vld <= '0;
        end else begin
            vld[0] <= start;
            for (int s = 1; s < NSUM; s++) begin
                vld[s] <= vld[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_q[0] <= is_signed ? {{32{a[31]}}, a} : {32'd0, a};
            b_q[0] <= {32'd0, b};
            // negative b contributes -a * 2^32
            acc_q[0] <= (is_signed & b[31]) ? {~a + 32'd1, 32'd0} : 64'd0;
        end
        for (int s = 1; s < NSUM; s++) begin
            if (vld[s-1]) begin
                a_q[s] <= a_q[s-1];
                b_q[s] <= b_q[s-1];
            end
        end
        for (int s = 1; s < MULT_STAGES; s++) begin
            if (vld[s-1]) begin
                acc_q[s] <= acc_q[s-1] + pp[s-1];
            end
        end
    end

    assign product = acc_q[MULT_STAGES-1];

endmodule

/* hdl/alu_logic_shift.sv */
`timescale 1ns/1ps

module alu_logic_shift (
    input  logic [31:0]         src_a,
    input  logic [31:0]         src_b,
    input  logic [4:0]          sa,
    input  ex_op_pkg::ex_ctrl_t ctrl,
    output logic [31:0]         result
);
    logic [31:0] logic_res;
    logic [4:0]  shamt;
    logic [63:0] right_wide;
    logic [31:0] shift_res;

    always_comb begin
        case (ctrl.logic_sel)
            ex_op_pkg::LOGIC_AND: logic_res = src_a & src_b;
            ex_op_pkg::LOGIC_OR:  logic_res = src_a | src_b;
            ex_op_pkg::LOGIC_NOR: logic_res = ~(src_a | src_b);
            default:              logic_res = src_a ^ src_b;
        endcase
    end

    assign shamt = ctrl.shift_by_sa ? sa : src_a[4:0];

    // sign or zero fill in the upper word
    assign right_wide = {{32{ctrl.shift_arith & src_b[31]}}, src_b} >> shamt;
    assign shift_res  = ctrl.shift_right ? right_wide[31:0] : (src_b << shamt);

    always_comb begin
        case (ctrl.ls_sel)
            ex_op_pkg::LS_LOGIC: result = logic_res;
            ex_op_pkg::LS_SHIFT: result = shift_res;
            ex_op_pkg::LS_LUI:   result = {src_b[15:0], 16'd0};
            default:             result = src_a;   // pass-through
        endcase
    end

endmodule

/* hdl/alu_arith.sv */
`timescale 1ns/1ps

module alu_arith (
    input  logic [31:0]         src_a,
    input  logic [31:0]         src_b,
    input  ex_op_pkg::ex_ctrl_t ctrl,
    output logic [31:0]         sum,
    output logic                slt_bit,
    output logic                sltu_bit,
    output logic                overflow,
    output logic [31:0]         result
);
    logic [31:0] b_eff;
    logic        cout;

    assign b_eff = src_b ^ {32{ctrl.sub_en}};
    assign {cout, sum} = {1'b0, src_a} + {1'b0, b_eff} + {32'd0, ctrl.sub_en};

    // no borrow out means a >= b
    assign sltu_bit = ~cout;
    assign slt_bit  = (src_a[31] & ~src_b[31]) | (~(src_a[31] ^ src_b[31]) & sum[31]);

    // same-sign inputs, sign flipped in the sum
    assign overflow = ctrl.trap_en & ~(src_a[31] ^ b_eff[31]) & (sum[31] ^ src_a[31]);

    always_comb begin
        if (ctrl.slt_en) begin
            result = {31'd0, ctrl.signed_op ? slt_bit : sltu_bit};
        end else begin
            result = sum;
        end
    end

endmodule

/* hdl/ex_data_pkg.sv */
package ex_data_pkg;

    typedef struct packed {
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic [4:0]  sa;
    } ex_operands_t;

    // also the HI/LO pair
    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } wide_result_t;

endpackage

/* hdl/ex_op_pkg.sv */
package ex_op_pkg;

    typedef enum logic [4:0] {
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SLL_SA,
        ALU_SRL,
        ALU_SRA,
        ALU_SRL_SA,
        ALU_SRA_SA,
        ALU_LUI,
        ALU_PASS,
        ALU_MTHI,
        ALU_MTLO,
        ALU_MULT,
        ALU_MULTU,
        ALU_DIV,
        ALU_DIVU
    } alu_op_e;

    typedef enum logic [1:0] {
        LOGIC_AND,
        LOGIC_OR,
        LOGIC_NOR,
        LOGIC_XOR
    } logic_sel_e;

    // result source inside alu_logic_shift
    typedef enum logic [1:0] {
        LS_LOGIC,
        LS_SHIFT,
        LS_LUI,
        LS_PASS
    } ls_sel_e;

    typedef enum logic [2:0] {
        RES_LS,
        RES_ARITH,
        RES_MULT,
        RES_DIV,
        RES_MTHI,
        RES_MTLO
    } res_sel_e;

    typedef struct packed {
        logic       sub_en;      // invert b, carry in
        logic       signed_op;
        logic       trap_en;     // add/sub may raise overflow
        logic       slt_en;
        ls_sel_e    ls_sel;
        logic_sel_e logic_sel;
        logic       shift_by_sa;
        logic       shift_right;
        logic       shift_arith;
    } ex_ctrl_t;

endpackage
